/* sim.f */
+incdir+.
video_pkg.sv
timing_if.sv
video_mode_table.sv
raster_timing.sv
aux_burst_reader.sv
hdmi_tx_timing_top.sv
tb_clock_gen.sv
tb_hdmi_tx_timing.sv

/* tb_hdmi_tx_timing.sv */
`timescale 1ns/1ns
`include "video_defs.svh"

module tb_hdmi_tx_timing import video_pkg::*; ();

	localparam int VGA_LINE  = `VID_VGA_HPIXELS + `VID_VGA_HFP + `VID_VGA_HSPW + `VID_VGA_HBP;
	localparam int VGA_ROWS  = `VID_VGA_VLINES + `VID_VGA_VFP + `VID_VGA_VSPW + `VID_VGA_VBP;
	localparam int SVGA_LINE = `VID_SVGA_HPIXELS + `VID_SVGA_HFP + `VID_SVGA_HSPW + `VID_SVGA_HBP;
	localparam int SVGA_ROWS = `VID_SVGA_VLINES + `VID_SVGA_VFP + `VID_SVGA_VSPW + `VID_SVGA_VBP;
	localparam int HD_LINE   = `VID_HDTV720P_HPIXELS + `VID_HDTV720P_HFP
		+ `VID_HDTV720P_HSPW + `VID_HDTV720P_HBP;
	localparam int HD_ROWS   = `VID_HDTV720P_VLINES + `VID_HDTV720P_VFP
		+ `VID_HDTV720P_VSPW + `VID_HDTV720P_VBP;
	// Three VGA, two SVGA, one 720p frame, plus 10 %
	localparam int LIMIT = (3 * VGA_LINE * VGA_ROWS + 2 * SVGA_LINE * SVGA_ROWS
		+ HD_LINE * HD_ROWS) * 11 / 10;
	localparam int OUT_LAG = 2; // Sync and de trail the counters

	logic pclk, rst_n;
	logic [3:0] mode_sw;
	logic aux_empty, aux_more;
	logic hsync, vsync, de, aux_rd;
	vid_cnt_t pixel_x, pixel_y;

	int seed = 32'h8442_6ca2;
	int cycles = 0;
	int exp_total, exp_hpix, exp_hspw, exp_vspw, exp_vlines;
	logic exp_neg;
	logic line_en = 1'b0, frame_en = 1'b0;
	int line_checks = 0, frame_checks = 0;
	// Line monitor state
	logic de_d, hs_d, vs_d, de_seen, hs_seen, vs_seen;
	int de_run, hs_run, vs_run, prev_rise_y, prev_rise_cyc, de_rises;
	// Aux FIFO model and burst monitor
	int bursts_left = 0, rd_cnt = 0;
	int rd_run = 0, gap_run = 0, bursts_in_frame = 0, rd_cycles = 0;
	logic rd_d = 1'b0;
	int n_bursts;

	tb_clock_gen u_clk (.pclk(pclk), .rst_n(rst_n));

	hdmi_tx_timing_top DUT (
		.pclk(pclk), .rst_n(rst_n), .mode_sw(mode_sw),
		.aux_empty(aux_empty), .aux_more(aux_more),
		.hsync(hsync), .vsync(vsync), .de(de),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .aux_rd(aux_rd)
	);

	task automatic check_eq(string name, int expected, int actual);
		assert (expected == actual) else begin
			$display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic abort_run(string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	// Expected timing for one format, from the defs header
	task automatic load_format(input logic [3:0] code);
		case (code)
			MODE_VGA: begin
				exp_total = VGA_LINE;
				exp_hpix = `VID_VGA_HPIXELS;
				exp_hspw = `VID_VGA_HSPW;
				exp_neg = `VID_VGA_NEG_SYNC;
				exp_vspw = `VID_VGA_VSPW;
				exp_vlines = `VID_VGA_VLINES;
			end
			MODE_SVGA: begin
				exp_total = SVGA_LINE;
				exp_hpix = `VID_SVGA_HPIXELS;
				exp_hspw = `VID_SVGA_HSPW;
				exp_neg = `VID_SVGA_NEG_SYNC;
				exp_vspw = `VID_SVGA_VSPW;
				exp_vlines = `VID_SVGA_VLINES;
			end
			default: begin
				exp_total = HD_LINE;
				exp_hpix = `VID_HDTV720P_HPIXELS;
				exp_hspw = `VID_HDTV720P_HSPW;
				exp_neg = `VID_HDTV720P_NEG_SYNC;
				exp_vspw = `VID_HDTV720P_VSPW;
				exp_vlines = `VID_HDTV720P_VLINES;
			end
		endcase
		de_seen = 1'b0; // Drop partial runs
		hs_seen = 1'b0;
		vs_seen = 1'b0;
	endtask

	task automatic wait_frame_start();
		@(negedge pclk);
		while (!(pixel_x == 0 && pixel_y == 0))
			@(negedge pclk);
	endtask

	task automatic check_reset(string name);
		check_eq({name, " de"}, 0, de);
		check_eq({name, " aux_rd"}, 0, aux_rd);
		check_eq({name, " pixel_x"}, 0, pixel_x);
		check_eq({name, " pixel_y"}, 0, pixel_y);
		check_eq({name, " hsync idle"}, `VID_VGA_NEG_SYNC, hsync);
		check_eq({name, " vsync idle"}, `VID_VGA_NEG_SYNC, vsync);
	endtask

	// Watchdog
	always @(posedge pclk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
			abort_run("Timeout: simulation ran past its cycle limit");
	end

	// FIFO model drives flags from its burst count
	always @(posedge pclk) begin
		aux_empty <= (bursts_left == 0);
		aux_more  <= (bursts_left > 1); // Sampled on the last read
	end

	//////////////////////////////
	// Output monitors
	//////////////////////////////
	always @(negedge pclk) begin
		if (aux_rd && de)
			abort_run("Aux read happened while de was high");
		if (aux_rd) begin
			rd_cycles = rd_cycles + 1;
			rd_cnt = rd_cnt + 1;
			if (rd_cnt == `AUX_BURST_LEN) begin // One burst drained
				rd_cnt = 0;
				if (bursts_left > 0)
					bursts_left = bursts_left - 1;
			end
		end
		if (aux_rd && !rd_d && bursts_in_frame > 0)
			check_eq("aux gap length", `AUX_BURST_GAP, gap_run);
		if (!aux_rd && rd_d) begin
			check_eq("aux burst length", `AUX_BURST_LEN, rd_run);
			bursts_in_frame = bursts_in_frame + 1;
		end
		rd_run  = aux_rd ? rd_run + 1 : 0;
		gap_run = aux_rd ? 0 : gap_run + 1;
		rd_d    = aux_rd;

		if (line_en) begin
			if (de && !de_d) begin
				if (de_seen && pixel_y == prev_rise_y + 1) begin
					check_eq("line total", exp_total, cycles - prev_rise_cyc);
					line_checks = line_checks + 1;
				end
				check_eq("hsync idle at de", exp_neg, hsync);
				check_eq("de lag behind pixel_x", OUT_LAG, pixel_x);
				de_seen = 1'b1;
				prev_rise_y = pixel_y;
				prev_rise_cyc = cycles;
				de_rises = de_rises + 1;
			end
			if (!de && de_d && de_seen)
				check_eq("de width", exp_hpix, de_run);
			if ((hsync == exp_neg) && (hs_d != exp_neg) && hs_seen)
				check_eq("hsync width", exp_hspw, hs_run);
			if ((hsync != exp_neg) && (hs_d == exp_neg))
				hs_seen = 1'b1;
		end
		if (frame_en && (vsync != exp_neg) && (vs_d == exp_neg)) begin
			if (vs_seen) begin
				check_eq("de lines per frame", exp_vlines, de_rises);
				frame_checks = frame_checks + 1;
			end
			vs_seen = 1'b1;
			de_rises = 0;
		end
		if (frame_en && (vsync == exp_neg) && (vs_d != exp_neg) && vs_seen)
			check_eq("vsync width", exp_vspw * exp_total, vs_run);
		de_run = de ? de_run + 1 : 0;
		hs_run = (hsync != exp_neg) ? hs_run + 1 : 0;
		vs_run = (vsync != exp_neg) ? vs_run + 1 : 0;
		de_d = de;
		hs_d = hsync;
		vs_d = vsync;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		mode_sw   = MODE_VGA;
		aux_empty = 1'b1;
		aux_more  = 1'b0;
		de_d = 1'b0;
		hs_d = 1'b1;
		vs_d = 1'b1;
		de_run = 0;
		hs_run = 0;
		vs_run = 0;
		de_rises = 0;
		load_format(MODE_VGA);

		@(posedge pclk);
		@(negedge pclk);
		while (!rst_n) begin
			check_reset("reset");
			@(negedge pclk);
		end
		check_reset("after reset");
		line_en  = 1'b1;
		frame_en = 1'b1;

		wait_frame_start(); // Frame A, FIFO empty throughout
		wait_frame_start(); // Frame B, FIFO still empty
		n_bursts = 1 + ($unsigned($random(seed)) % 3);
		bursts_left = n_bursts;
		bursts_in_frame = 0;
		rd_cycles = 0;
		wait_frame_start(); // Frame C, FIFO loaded but audio gated off
		check_eq("audio gate reads", 0, rd_cycles);
		bursts_in_frame = 0;
		wait_frame_start(); // Frame D carries the bursts
		check_eq("aux burst count", n_bursts, bursts_in_frame);
		check_eq("VGA line checks reached", 1, line_checks > 0);
		check_eq("VGA frame checks reached", 1, frame_checks > 0);

		// VGA to 720p
		line_en  = 1'b0;
		frame_en = 1'b0;
		@(posedge pclk);
		mode_sw <= MODE_720P;
		repeat (4) @(posedge pclk);
		wait_frame_start();
		load_format(MODE_720P);
		line_checks = 0;
		line_en = 1'b1;
		while (line_checks < 10)
			@(negedge pclk);

		// 720p to SVGA
		line_en = 1'b0;
		@(posedge pclk);
		mode_sw <= MODE_SVGA;
		repeat (4) @(posedge pclk);
		wait_frame_start();
		load_format(MODE_SVGA);
		line_checks = 0;
		line_en = 1'b1;
		while (line_checks < 10)
			@(negedge pclk);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
	output logic pclk,
	output logic rst_n
);

	initial begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk; // 8 ns period
	end

	// Reset held over five rising edges
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge pclk);
		rst_n <= 1'b1;
	end

endmodule

/* hdmi_tx_timing_top.sv */
`timescale 1ns/1ns

module hdmi_tx_timing_top import video_pkg::*; (
	input  logic       pclk,
	input  logic       rst_n,
	input  logic [3:0] mode_sw,   // Raw format switches
	input  logic       aux_empty, // Aux FIFO flag
	input  logic       aux_more,  // More bursts field of FIFO word
	output logic       hsync,
	output logic       vsync,
	output logic       de,
	output vid_cnt_t   pixel_x,
	output vid_cnt_t   pixel_y,
	output logic       aux_rd     // Aux FIFO read and encoder aux enable
);

	logic line_start;
	logic frame_start;
	logic vblank;

	timing_if tmg ();

	video_mode_table u_mode (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.mode_sw (mode_sw),
		.tmg     (tmg)
	);

	raster_timing u_raster (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.tmg         (tmg),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.line_start  (line_start),
		.frame_start (frame_start),
		.vblank      (vblank)
	);

	// Uses the delayed de so arming follows what the sink saw
	aux_burst_reader u_aux (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.tmg         (tmg),
		.pixel_x     (pixel_x),
		.line_start  (line_start),
		.frame_start (frame_start),
		.vblank      (vblank),
		.de          (de),
		.aux_empty   (aux_empty),
		.aux_more    (aux_more),
		.aux_rd      (aux_rd)
	);

endmodule

/* aux_burst_reader.sv */
`timescale 1ns/1ns
`include "video_defs.svh"

module aux_burst_reader import video_pkg::*; (
	input  logic     pclk,
	input  logic     rst_n,
	timing_if.sink   tmg,
	input  vid_cnt_t pixel_x,
	input  logic     line_start,
	input  logic     frame_start,
	input  logic     vblank,
	input  logic     de,
	input  logic     aux_empty,
	input  logic     aux_more,
	output logic     aux_rd
);

	localparam int CNT_W = $clog2(`AUX_BURST_LEN);
	localparam logic [CNT_W-1:0] LAST_RD  = CNT_W'(`AUX_BURST_LEN - 1);
	localparam logic [CNT_W-1:0] LAST_GAP = CNT_W'(`AUX_BURST_GAP - 1);

	burst_state_e     state;
	logic [CNT_W-1:0] cnt;        // Position within read or gap
	logic             more_q;     // More bursts follow
	logic             audio_seen; // Aux traffic in the running frame
	logic             audio_on;   // Aux traffic in the previous frame
	logic             video_seen; // Sticky after first de
	logic             armed;      // Line may carry a burst
	logic             start;
	logic             rd_sched;

	//////////////////////////////
	// Audio presence
	//////////////////////////////
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			audio_seen <= 1'b0;
			audio_on   <= 1'b0;
		end else if (frame_start) begin
			audio_on   <= audio_seen; // Hand over to the new frame
			audio_seen <= !aux_empty;
		end else if (!aux_empty) begin
			audio_seen <= 1'b1;
		end
	end

	// Line arming, decided once at the start of each line
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			video_seen <= 1'b0;
			armed      <= 1'b0;
		end else begin
			if (de)
				video_seen <= 1'b1;
			if (line_start)
				armed <= video_seen && vblank && !aux_empty;
		end
	end

	// Burst fires at the hsync column
	assign start    = (state == BURST_IDLE) && armed && (pixel_x == tmg.hssync);
	assign rd_sched = start || (state == BURST_READ);

	//////////////////////////////
	// Burst scheduler
	//////////////////////////////
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			state  <= BURST_IDLE;
			cnt    <= '0;
			more_q <= 1'b0;
		end else if (line_start && !vblank) begin // Active video kills any sequence
			state <= BURST_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				BURST_IDLE: if (start) begin
					state <= BURST_READ;
					cnt   <= CNT_W'(1); // Start cycle is the first read
				end
				BURST_READ: if (cnt == LAST_RD) begin
					state  <= BURST_GAP;
					cnt    <= '0;
					more_q <= aux_more; // Sampled on last read
				end else begin
					cnt <= cnt + 1'b1;
				end
				BURST_GAP: if (cnt == LAST_GAP) begin
					state <= more_q ? BURST_READ : BURST_IDLE;
					cnt   <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
				default: state <= BURST_IDLE;
			endcase
		end
	end

	// Read strobe doubles as aux data enable
	always_ff @(posedge pclk) begin
		if (!rst_n)
			aux_rd <= 1'b0;
		else
			aux_rd <= rd_sched && audio_on; // Silent frame means no reads
	end

endmodule

/* raster_timing.sv */
`timescale 1ns/1ns

module raster_timing import video_pkg::*; (
	input  logic     pclk,
	input  logic     rst_n,
	timing_if.sink   tmg,
	output logic     hsync,
	output logic     vsync,
	output logic     de,
	output vid_cnt_t pixel_x,
	output vid_cnt_t pixel_y,
	output logic     line_start,
	output logic     frame_start,
	output logic     vblank
);

	vid_cnt_t hcount;
	vid_cnt_t vcount;
	logic     hblnk;
	logic     hsync_int;
	logic     vsync_int;
	logic     active;
	// First delay stage
	logic     hsync_q;
	logic     vsync_q;
	logic     active_q;

	//////////////////////////////
	// Pixel and line counters
	//////////////////////////////
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			hcount <= '0;
			vcount <= '0;
		end else if (hcount >= tmg.heblnk) begin // Also catches overshoot after a mode change
			hcount <= '0;
			if (vcount >= tmg.veblnk)
				vcount <= '0;
			else
				vcount <= vcount + 1'b1;
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// Blanking and raw sync, active high
	assign hblnk     = hcount > tmg.hsblnk;
	assign hsync_int = (hcount > tmg.hssync) && (hcount <= tmg.hesync);
	assign vblank    = vcount > tmg.vsblnk;
	assign vsync_int = (vcount > tmg.vssync) && (vcount <= tmg.vesync);
	assign active    = !hblnk && !vblank;

	// Position and line markers, undelayed
	assign pixel_x     = hcount;
	assign pixel_y     = vcount;
	assign line_start  = hcount == '0;
	assign frame_start = line_start && (vcount == '0); // First pixel of the frame

	//////////////////////////////
	// Output pipeline
	//////////////////////////////
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			hsync_q  <= tmg.neg_sync; // Park at inactive level
			vsync_q  <= tmg.neg_sync;
			active_q <= 1'b0;
			hsync    <= tmg.neg_sync;
			vsync    <= tmg.neg_sync;
			de       <= 1'b0;
		end else begin
			// Stage one flips polarity
			hsync_q  <= hsync_int ^ tmg.neg_sync;
			vsync_q  <= vsync_int ^ tmg.neg_sync;
			active_q <= active;
			// Stage two lines up with pixel data
			hsync    <= hsync_q;
			vsync    <= vsync_q;
			de       <= active_q;
		end
	end

endmodule

/* video_mode_table.sv */
`timescale 1ns/1ns
`include "video_defs.svh"

module video_mode_table import video_pkg::*; (
	input  logic       pclk,
	input  logic       rst_n,
	input  logic [3:0] mode_sw,
	timing_if.source   tmg
);

	logic [3:0]  sw_meta;   // First synchroniser stage
	logic [3:0]  sw_sync;   // Second synchroniser stage
	video_mode_e mode_q;    // Registered mode code
	vid_cnt_t    h_fmt [4]; // Active, front porch, sync, back porch
	vid_cnt_t    v_fmt [4];
	logic        neg;

	//////////////////////////////
	// Switch capture
	//////////////////////////////
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
			mode_q  <= MODE_VGA;
		end else begin
			sw_meta <= mode_sw;
			sw_sync <= sw_meta;
			case (sw_sync)
				MODE_VGA, MODE_SVGA, MODE_720P, MODE_XGA, MODE_SXGA, MODE_CAMERA:
					mode_q <= video_mode_e'(sw_sync);
				default:
					mode_q <= MODE_720P; // Unused codes fall back to 720p
			endcase
		end
	end

	//////////////////////////////
	// Format lookup
	//////////////////////////////
	always_comb begin
		case (rst_n ? mode_q : MODE_VGA) // Reset selects VGA from its first edge
			MODE_VGA: begin
				h_fmt = '{`VID_VGA_HPIXELS, `VID_VGA_HFP, `VID_VGA_HSPW, `VID_VGA_HBP};
				v_fmt = '{`VID_VGA_VLINES, `VID_VGA_VFP, `VID_VGA_VSPW, `VID_VGA_VBP};
				neg   = `VID_VGA_NEG_SYNC;
			end
			MODE_SVGA: begin
				h_fmt = '{`VID_SVGA_HPIXELS, `VID_SVGA_HFP, `VID_SVGA_HSPW, `VID_SVGA_HBP};
				v_fmt = '{`VID_SVGA_VLINES, `VID_SVGA_VFP, `VID_SVGA_VSPW, `VID_SVGA_VBP};
				neg   = `VID_SVGA_NEG_SYNC;
			end
			MODE_XGA: begin
				h_fmt = '{`VID_XGA_HPIXELS, `VID_XGA_HFP, `VID_XGA_HSPW, `VID_XGA_HBP};
				v_fmt = '{`VID_XGA_VLINES, `VID_XGA_VFP, `VID_XGA_VSPW, `VID_XGA_VBP};
				neg   = `VID_XGA_NEG_SYNC;
			end
			MODE_SXGA: begin
				h_fmt = '{`VID_SXGA_HPIXELS, `VID_SXGA_HFP, `VID_SXGA_HSPW, `VID_SXGA_HBP};
				v_fmt = '{`VID_SXGA_VLINES, `VID_SXGA_VFP, `VID_SXGA_VSPW, `VID_SXGA_VBP};
				neg   = `VID_SXGA_NEG_SYNC;
			end
			MODE_CAMERA: begin
				h_fmt = '{`VID_CAMERA_HPIXELS, `VID_CAMERA_HFP, `VID_CAMERA_HSPW, `VID_CAMERA_HBP};
				v_fmt = '{`VID_CAMERA_VLINES, `VID_CAMERA_VFP, `VID_CAMERA_VSPW, `VID_CAMERA_VBP};
				neg   = `VID_CAMERA_NEG_SYNC;
			end
			default: begin // 720p
				h_fmt = '{`VID_HDTV720P_HPIXELS, `VID_HDTV720P_HFP,
					`VID_HDTV720P_HSPW, `VID_HDTV720P_HBP};
				v_fmt = '{`VID_HDTV720P_VLINES, `VID_HDTV720P_VFP,
					`VID_HDTV720P_VSPW, `VID_HDTV720P_VBP};
				neg   = `VID_HDTV720P_NEG_SYNC;
			end
		endcase
	end

	// Thresholds accumulate left to right along the line
	assign tmg.hsblnk   = h_fmt[0] - 1'b1;
	assign tmg.hssync   = h_fmt[0] - 1'b1 + h_fmt[1];
	assign tmg.hesync   = h_fmt[0] - 1'b1 + h_fmt[1] + h_fmt[2];
	assign tmg.heblnk   = h_fmt[0] - 1'b1 + h_fmt[1] + h_fmt[2] + h_fmt[3]; // Line total - 1
	assign tmg.vsblnk   = v_fmt[0] - 1'b1;
	assign tmg.vssync   = v_fmt[0] - 1'b1 + v_fmt[1];
	assign tmg.vesync   = v_fmt[0] - 1'b1 + v_fmt[1] + v_fmt[2];
	assign tmg.veblnk   = v_fmt[0] - 1'b1 + v_fmt[1] + v_fmt[2] + v_fmt[3];
	assign tmg.neg_sync = neg;

endmodule

/* timing_if.sv */
`timescale 1ns/1ns

interface timing_if import video_pkg::*; ();

	// Horizontal thresholds in pixels
	vid_cnt_t hsblnk;
	vid_cnt_t hssync;
	vid_cnt_t hesync;
	vid_cnt_t heblnk;
	// Vertical thresholds in lines
	vid_cnt_t vsblnk;
	vid_cnt_t vssync;
	vid_cnt_t vesync;
	vid_cnt_t veblnk;
	logic     neg_sync; // 1 for active low sync

	modport source (output hsblnk, hssync, hesync, heblnk,
		vsblnk, vssync, vesync, veblnk, neg_sync);
	modport sink (input hsblnk, hssync, hesync, heblnk,
		vsblnk, vssync, vesync, veblnk, neg_sync);

endinterface

/* video_pkg.sv */
`include "video_defs.svh"

package video_pkg;

	// Pixel and line counter, also used for all thresholds
	typedef logic [`VID_CNT_W-1:0] vid_cnt_t;

	// Mode switch codes
	typedef enum logic [3:0] {
		MODE_VGA    = 4'b0000,
		MODE_SVGA   = 4'b0001,
		MODE_720P   = 4'b0010, // Also taken for any unlisted code
		MODE_XGA    = 4'b0011,
		MODE_SXGA   = 4'b1000,
		MODE_CAMERA = 4'b1001
	} video_mode_e;

	// Aux burst scheduler
	typedef enum logic [1:0] {
		BURST_IDLE,  // Waiting for the hsync column
		BURST_READ,  // Reads in flight
		BURST_GAP    // Spacing before the next burst
	} burst_state_e;

endpackage

/* video_defs.svh */
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

`define VID_CNT_W 11 // Width of every counter and threshold

//////////////////////////////
// Display formats
//////////////////////////////

// 640x480 at 60 Hz
`define VID_VGA_HPIXELS       640
`define VID_VGA_VLINES        480
`define VID_VGA_HFP           16
`define VID_VGA_VFP           11
`define VID_VGA_HSPW          96
`define VID_VGA_VSPW          2
`define VID_VGA_HBP           48
`define VID_VGA_VBP           31
`define VID_VGA_NEG_SYNC      1 // Sync active low

// 800x600 at 60 Hz
`define VID_SVGA_HPIXELS      800
`define VID_SVGA_VLINES       600
`define VID_SVGA_HFP          40
`define VID_SVGA_VFP          1
`define VID_SVGA_HSPW         128
`define VID_SVGA_VSPW         4
`define VID_SVGA_HBP          88
`define VID_SVGA_VBP          23
`define VID_SVGA_NEG_SYNC     0

// 1024x768 at 60 Hz
`define VID_XGA_HPIXELS       1024
`define VID_XGA_VLINES        768
`define VID_XGA_HFP           24
`define VID_XGA_VFP           3
`define VID_XGA_HSPW          136
`define VID_XGA_VSPW          6
`define VID_XGA_HBP           160
`define VID_XGA_VBP           29
`define VID_XGA_NEG_SYNC      1 // Sync active low

// 1280x1024 at 60 Hz
`define VID_SXGA_HPIXELS      1280
`define VID_SXGA_VLINES       1024
`define VID_SXGA_HFP          48
`define VID_SXGA_VFP          1
`define VID_SXGA_HSPW         112
`define VID_SXGA_VSPW         3
`define VID_SXGA_HBP          248
`define VID_SXGA_VBP          38
`define VID_SXGA_NEG_SYNC     0

// 1280x720 at 60 Hz
`define VID_HDTV720P_HPIXELS  1280
`define VID_HDTV720P_VLINES   720
`define VID_HDTV720P_HFP      110
`define VID_HDTV720P_VFP      5
`define VID_HDTV720P_HSPW     40
`define VID_HDTV720P_VSPW     5
`define VID_HDTV720P_HBP      220
`define VID_HDTV720P_VBP      20
`define VID_HDTV720P_NEG_SYNC 0

// Camera source, 720p with trimmed sync and porches
`define VID_CAMERA_HPIXELS    1280
`define VID_CAMERA_VLINES     720
`define VID_CAMERA_HFP        110
`define VID_CAMERA_VFP        4
`define VID_CAMERA_HSPW       39
`define VID_CAMERA_VSPW       4
`define VID_CAMERA_HBP        220
`define VID_CAMERA_VBP        22
`define VID_CAMERA_NEG_SYNC   0

// Aux burst shape
`define AUX_BURST_LEN 32 // Reads per burst
`define AUX_BURST_GAP 4  // Idle cycles after each burst

`endif
